// File: filelist.f
design/pe_pkg.sv
design/loop_counter.sv
design/scratch_pad.sv
design/pe_controller.sv
design/pe_mac.sv
design/pe_top.sv
verification/pe_checker.sv
verification/pe_tb.sv

// File: verification/pe_tb.sv
`timescale 1ns/1ps

module pe_tb;
    import pe_pkg::*;

    localparam int NUM_TESTS = 34;
    localparam int TIMEOUT   = 2000 * NUM_TESTS + 500;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic start = 1'b0;
    logic abort = 1'b0;
    logic stall = 1'b0;
    logic wt_rdy = 1'b0;
    logic in_rdy = 1'b0;
    logic ps_ack = 1'b0;
    logic hold_ack = 1'b0;
    logic test_end = 1'b0;
    logic signed [ACT_W-1:0] wt_data = '0;
    logic signed [ACT_W-1:0] in_data = '0;
    pe_conf_t conf = '0;
    pe_inst_t inst;

    logic wt_ack, in_ack, ps_rdy, done;
    logic signed [PSUM_W-1:0] ps_data;

    int seed;
    int rdy_gap = 0;
    int ack_gap = 0;
    int stall_pct = 0;
    int test_kind = 0;
    int test_num = 0;
    int cycles = 0;
    int pass_cnt, fail_cnt;

    assign inst = '{start: start, abort: abort, stall: stall};

    always #4 clk = ~clk;

    pe_top #(.IPAD_DEPTH(96), .WPAD_DEPTH(32)) i_pe_top (
        .i_clk (clk), .i_rst_n (rst_n), .i_conf (conf), .i_inst (inst),
        .i_wt_rdy (wt_rdy), .i_wt_data (wt_data), .o_wt_ack (wt_ack),
        .i_in_rdy (in_rdy), .i_in_data (in_data), .o_in_ack (in_ack),
        .o_ps_rdy (ps_rdy), .o_ps_data (ps_data), .i_ps_ack (ps_ack),
        .o_done (done)
    );

    pe_checker u_checker (
        .i_clk (clk), .i_rst_n (rst_n), .i_conf (conf), .i_inst (inst),
        .i_wt_rdy (wt_rdy), .i_wt_data (wt_data), .i_wt_ack (wt_ack),
        .i_in_rdy (in_rdy), .i_in_data (in_data), .i_in_ack (in_ack),
        .i_ps_rdy (ps_rdy), .i_ps_data (ps_data), .i_ps_ack (ps_ack),
        .i_done (done), .i_test_kind (test_kind), .i_test_num (test_num),
        .i_test_end (test_end), .o_pass_cnt (pass_cnt), .o_fail_cnt (fail_cnt)
    );

    function automatic int rand_range(int lo, int hi);
        return lo + (($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
    endfunction

    function automatic bit percent_hit(int pct);
        return rand_range(0, 99) < pct;
    endfunction

    // ==================================================================
    // stream sources, data holds until taken
    // ==================================================================
    always @(posedge clk) begin
        if (rst_n && (!wt_rdy || wt_ack)) begin
            wt_rdy  <= !percent_hit(rdy_gap);
            wt_data <= $random(seed);
        end
        if (rst_n && (!in_rdy || in_ack)) begin
            in_rdy  <= !percent_hit(rdy_gap);
            in_data <= $random(seed);
        end
        ps_ack <= rst_n && !hold_ack && !percent_hit(ack_gap);
        stall  <= rst_n && percent_hit(stall_pct);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic begin_test(input int kind, input int num);
        @(posedge clk);
        test_kind <= kind;
        test_num  <= num;
    endtask

    task automatic finish_test();
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    task automatic start_run(input int ch, input int filt, input int outw);
        @(posedge clk);
        conf.ch_num <= ch[2:0];
        conf.filt_w <= filt[3:0];
        conf.out_w  <= outw[4:0];
        start       <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        do @(negedge clk); while (!done);
        @(posedge clk);
    endtask

    task automatic random_run();
        int ch, filt, outw;
        ch   = rand_range(1, MAX_CH);
        filt = rand_range(1, MAX_FILT);
        outw = rand_range(1, MAX_OUT);
        start_run(ch, filt, outw);
        wait_done();
    endtask

    initial begin
        seed = 14104;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // idle with live streams, no start
        begin_test(0, 0);
        rdy_gap <= 30;
        ack_gap <= 30;
        repeat (20) @(posedge clk);
        finish_test();

        begin_test(1, 0);
        rdy_gap <= 0;
        ack_gap <= 0;
        start_run(1, 3, 4);
        wait_done();
        finish_test();

        for (int n = 0; n < 20; n++) begin
            begin_test(2, n);
            random_run();
            finish_test();
        end

        rdy_gap <= 40;
        ack_gap <= 60;
        for (int n = 0; n < 5; n++) begin
            begin_test(3, n);
            random_run();
            finish_test();
        end

        rdy_gap   <= 10;
        ack_gap   <= 20;
        stall_pct <= 25;
        for (int n = 0; n < 5; n++) begin
            begin_test(4, n);
            random_run();
            finish_test();
        end

        // abort a few cycles after the first psum leaves
        begin_test(5, 0);
        stall_pct <= 0;
        start_run(2, 3, 12);
        do @(negedge clk); while (!(ps_rdy && ps_ack));
        repeat (rand_range(1, 3)) @(posedge clk);
        hold_ack <= 1'b1;
        @(posedge clk);
        abort <= 1'b1;
        @(posedge clk);
        abort    <= 1'b0;
        hold_ack <= 1'b0;
        repeat (30) @(posedge clk);
        finish_test();

        begin_test(6, 0);
        random_run();
        finish_test();

        repeat (2) @(posedge clk);
        $display("tests: %0d passed, %0d failed of %0d", pass_cnt, fail_cnt, NUM_TESTS);
        if (fail_cnt == 0 && pass_cnt == NUM_TESTS) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verification/pe_checker.sv
`timescale 1ns/1ps

module pe_checker (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  pe_pkg::pe_conf_t                  i_conf,
    input  pe_pkg::pe_inst_t                  i_inst,
    input  logic                              i_wt_rdy,
    input  logic signed [pe_pkg::ACT_W-1:0]   i_wt_data,
    input  logic                              i_wt_ack,
    input  logic                              i_in_rdy,
    input  logic signed [pe_pkg::ACT_W-1:0]   i_in_data,
    input  logic                              i_in_ack,
    input  logic                              i_ps_rdy,
    input  logic signed [pe_pkg::PSUM_W-1:0]  i_ps_data,
    input  logic                              i_ps_ack,
    input  logic                              i_done,
    input  int                                i_test_kind,
    input  int                                i_test_num,
    input  logic                              i_test_end,
    output int                                o_pass_cnt,
    output int                                o_fail_cnt
);
    import pe_pkg::*;

    // captured stream data, in arrival order
    int wts [MAX_CH*MAX_FILT];
    int ins [MAX_CH*(MAX_OUT+MAX_FILT-1)];

    int ch, filt, outw, row;
    int wt_cnt, in_cnt, ps_cnt, errs;
    bit active, ps_wait;
    int ps_hold;

    function automatic string test_name(int kind, int num);
        string base;
        case (kind)
            0:       base = "reset_state";
            1:       base = "fixed_small";
            2:       base = "random_cfg";
            3:       base = "back_pressure";
            4:       base = "stall";
            5:       base = "abort";
            default: base = "after_abort";
        endcase
        return $sformatf("%s_%0d", base, num);
    endfunction

    // reference convolution, stride 1
    function automatic int expected_psum(int o);
        int sum;
        sum = 0;
        for (int c = 0; c < ch; c++) begin
            for (int r = 0; r < filt; r++) begin
                sum += wts[c*filt + r] * ins[c*row + o + r];
            end
        end
        return sum;
    endfunction

    task automatic value_error(string what, int exp_v, int act_v);
        $display("** Error [%s] %s: expected %0d, actual %0d",
                 test_name(i_test_kind, i_test_num), what, exp_v, act_v);
        errs++;
    endtask

    task automatic plain_error(string msg);
        $display("[%s] %s", test_name(i_test_kind, i_test_num), msg);
        errs++;
    endtask

    // ==================================================================
    // transfer tracking and comparison
    // ==================================================================
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            active     = 1'b0;
            ps_wait    = 1'b0;
            errs       = 0;
            o_pass_cnt = 0;
            o_fail_cnt = 0;
        end else if (i_inst.abort) begin
            // any waiting psum is dropped
            active  = 1'b0;
            ps_wait = 1'b0;
        end else if (!active) begin
            if (i_wt_ack || i_in_ack || i_ps_rdy || i_done) begin
                value_error("idle outputs", 0, {i_wt_ack, i_in_ack, i_ps_rdy, i_done});
            end
            if (i_inst.start) begin
                ch      = i_conf.ch_num;
                filt    = i_conf.filt_w;
                outw    = i_conf.out_w;
                row     = outw + filt - 1;
                wt_cnt  = 0;
                in_cnt  = 0;
                ps_cnt  = 0;
                ps_wait = 1'b0;
                active  = 1'b1;
            end
        end else begin
            if (i_wt_rdy && i_wt_ack) begin
                if (wt_cnt < ch*filt) begin
                    wts[wt_cnt] = i_wt_data;
                    wt_cnt++;
                end else begin
                    plain_error("weight taken after the weight load had finished");
                end
            end
            if (i_in_rdy && i_in_ack) begin
                if (wt_cnt == ch*filt && in_cnt < ch*row) begin
                    ins[in_cnt] = i_in_data;
                    in_cnt++;
                end else begin
                    plain_error("input pixel taken outside the input load");
                end
            end
            // psum must hold while it waits for an ack
            if (ps_wait && i_ps_rdy && i_ps_data != ps_hold) begin
                value_error("held psum", ps_hold, i_ps_data);
            end
            if (i_ps_rdy && i_ps_ack) begin
                if (ps_cnt < outw) begin
                    if (i_ps_data != expected_psum(ps_cnt)) begin
                        value_error($sformatf("psum %0d", ps_cnt), expected_psum(ps_cnt),
                                    i_ps_data);
                    end
                    ps_cnt++;
                end else begin
                    plain_error("more psums delivered than the output width");
                end
            end
            ps_wait = i_ps_rdy && !i_ps_ack;
            ps_hold = i_ps_data;
            if (i_done) begin
                if (ps_cnt != outw) value_error("psum count", outw, ps_cnt);
                if (wt_cnt != ch*filt) value_error("weight transfers", ch*filt, wt_cnt);
                if (in_cnt != ch*row) value_error("input transfers", ch*row, in_cnt);
                active = 1'b0;
            end
        end

        if (i_rst_n && i_test_end) begin
            if (active) plain_error("run still in progress at the end of the test");
            if (errs == 0) begin
                $display("%-18s ok", test_name(i_test_kind, i_test_num));
                o_pass_cnt++;
            end else begin
                $display("%-18s FAILED with %0d errors", test_name(i_test_kind, i_test_num), errs);
                o_fail_cnt++;
            end
            errs = 0;
        end
    end

endmodule

// File: design/pe_top.sv
`timescale 1ns/1ps

module pe_top #(
    parameter int IPAD_DEPTH = 96,
    parameter int WPAD_DEPTH = 32
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  pe_pkg::pe_conf_t                  i_conf,
    input  pe_pkg::pe_inst_t                  i_inst,
    // weight stream
    input  logic                              i_wt_rdy,
    input  logic signed [pe_pkg::ACT_W-1:0]   i_wt_data,
    output logic                              o_wt_ack,
    // input pixel stream
    input  logic                              i_in_rdy,
    input  logic signed [pe_pkg::ACT_W-1:0]   i_in_data,
    output logic                              o_in_ack,
    // psum stream
    output logic                              o_ps_rdy,
    output logic signed [pe_pkg::PSUM_W-1:0]  o_ps_data,
    input  logic                              i_ps_ack,
    output logic                              o_done
);
    import pe_pkg::*;

    pad_ctl_t wt_pad_ctl;
    pad_ctl_t in_pad_ctl;
    mac_ctl_t mac_ctl;
    logic     mac_busy;

    logic signed [ACT_W-1:0] wt_rdata;
    logic signed [ACT_W-1:0] in_rdata;

    pe_controller u_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_conf     (i_conf),
        .i_inst     (i_inst),
        .i_wt_rdy   (i_wt_rdy),
        .i_in_rdy   (i_in_rdy),
        .o_wt_ack   (o_wt_ack),
        .o_in_ack   (o_in_ack),
        .i_mac_busy (mac_busy),
        .o_wt_pad   (wt_pad_ctl),
        .o_in_pad   (in_pad_ctl),
        .o_mac      (mac_ctl),
        .i_ps_ack   (i_ps_ack),
        .o_done     (o_done)
    );

    scratch_pad #(.DEPTH(WPAD_DEPTH)) u_wt_pad (
        .i_clk   (i_clk),
        .i_ctl   (wt_pad_ctl),
        .i_wdata (i_wt_data),
        .o_rdata (wt_rdata)
    );

    scratch_pad #(.DEPTH(IPAD_DEPTH)) u_in_pad (
        .i_clk   (i_clk),
        .i_ctl   (in_pad_ctl),
        .i_wdata (i_in_data),
        .o_rdata (in_rdata)
    );

    // abort also drops any result still waiting in the MAC
    pe_mac u_mac (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_clear   (i_inst.abort),
        .i_ctl     (mac_ctl),
        .i_wt      (wt_rdata),
        .i_in      (in_rdata),
        .o_ps_rdy  (o_ps_rdy),
        .o_ps_data (o_ps_data),
        .i_ps_ack  (i_ps_ack),
        .o_busy    (mac_busy)
    );

endmodule

// File: design/pe_mac.sv
`timescale 1ns/1ps

module pe_mac (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_clear,
    input  pe_pkg::mac_ctl_t                  i_ctl,
    input  logic signed [pe_pkg::ACT_W-1:0]   i_wt,
    input  logic signed [pe_pkg::ACT_W-1:0]   i_in,
    output logic                              o_ps_rdy,
    output logic signed [pe_pkg::PSUM_W-1:0]  o_ps_data,
    input  logic                              i_ps_ack,
    output logic                              o_busy
);
    import pe_pkg::*;

    logic signed [2*ACT_W-1:0]  prod;
    logic signed [PSUM_W-1:0]   acc;
    logic signed [PSUM_W-1:0]   acc_base;
    logic signed [PSUM_W-1:0]   acc_nxt;
    logic                       fin;

    // ==================================================================
    // multiply and accumulate
    // ==================================================================
    assign prod     = i_wt * i_in;
    assign acc_base = i_ctl.first ? PSUM_W'(0) : acc;
    assign acc_nxt  = acc_base + PSUM_W'(prod);
    assign fin      = i_ctl.valid && i_ctl.last;

    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            acc <= '0;
        end else if (i_ctl.valid) begin
            acc <= acc_nxt;
        end
    end

    // ==================================================================
    // output psum register
    // ==================================================================
    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            o_ps_data <= '0;
        end else if (fin) begin
            o_ps_data <= acc_nxt;
        end
    end

    // a new result may land in the same cycle the old one is taken
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            o_ps_rdy <= 1'b0;
        end else if (fin) begin
            o_ps_rdy <= 1'b1;
        end else if (i_ps_ack) begin
            o_ps_rdy <= 1'b0;
        end
    end

    assign o_busy = o_ps_rdy;

endmodule

// File: design/pe_controller.sv
`timescale 1ns/1ps

module pe_controller (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  pe_pkg::pe_conf_t i_conf,
    input  pe_pkg::pe_inst_t i_inst,
    input  logic             i_wt_rdy,
    input  logic             i_in_rdy,
    output logic             o_wt_ack,
    output logic             o_in_ack,
    input  logic             i_mac_busy,
    output pe_pkg::pad_ctl_t o_wt_pad,
    output pe_pkg::pad_ctl_t o_in_pad,
    output pe_pkg::mac_ctl_t o_mac,
    input  logic             i_ps_ack,
    output logic             o_done
);
    import pe_pkg::*;

    localparam int WT_IDX_W = $clog2(((MAX_CH > MAX_FILT) ? MAX_CH : MAX_FILT) + 1);
    localparam int IN_IDX_W = $clog2(MAX_OUT + MAX_FILT);

    pe_state_e state, state_nxt;
    pe_conf_t  conf;

    logic [PAD_AW-1:0] wr_cnt;
    logic [IN_IDX_W-1:0] ps_cnt;
    logic [IN_IDX_W-1:0] row_w;

    logic run_ok;
    logic cnt_clear;
    logic wt_xfer, in_xfer, ps_xfer;
    logic wt_all_end, in_all_end, cmp_all_end;

    logic [1:0][WT_IDX_W-1:0] wt_size;
    logic [1:0][IN_IDX_W-1:0] in_size;
    logic [2:0][IN_IDX_W-1:0] cmp_size;
    logic [2:0][IN_IDX_W-1:0] cmp_idx;
    logic [2:0]               cmp_end;

    logic issue, issue_first, issue_last, hold_last, last_psum;
    logic [PAD_AW-1:0] wt_raddr, in_raddr;

    // ==================================================================
    // loop sizes and counters
    // ==================================================================
    assign row_w    = IN_IDX_W'(conf.out_w) + IN_IDX_W'(conf.filt_w) - 1'b1;
    assign wt_size  = {WT_IDX_W'(conf.ch_num), WT_IDX_W'(conf.filt_w)};
    assign in_size  = {IN_IDX_W'(conf.ch_num), row_w};
    // pixel outermost, tap innermost
    assign cmp_size = {IN_IDX_W'(conf.out_w), IN_IDX_W'(conf.ch_num), IN_IDX_W'(conf.filt_w)};

    assign run_ok    = !i_inst.stall && !i_inst.abort;
    assign cnt_clear = (state == IDLE) || i_inst.abort;

    loop_counter #(.NDEPTH(2), .IDX_W(WT_IDX_W)) u_wt_cnt (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_clear   (cnt_clear),
        .i_inc     (wt_xfer),
        .i_size    (wt_size),
        .o_idx     (),
        .o_end     (),
        .o_all_end (wt_all_end)
    );

    loop_counter #(.NDEPTH(2), .IDX_W(IN_IDX_W)) u_in_cnt (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_clear   (cnt_clear),
        .i_inc     (in_xfer),
        .i_size    (in_size),
        .o_idx     (),
        .o_end     (),
        .o_all_end (in_all_end)
    );

    loop_counter #(.NDEPTH(3), .IDX_W(IN_IDX_W)) u_cmp_cnt (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_clear   (cnt_clear),
        .i_inc     (issue),
        .i_size    (cmp_size),
        .o_idx     (cmp_idx),
        .o_end     (cmp_end),
        .o_all_end (cmp_all_end)
    );

    // ==================================================================
    // stream handshakes
    // ==================================================================
    assign o_wt_ack = (state == LOAD_WT) && run_ok;
    assign o_in_ack = (state == LOAD_IN) && run_ok;
    assign wt_xfer  = o_wt_ack && i_wt_rdy;
    assign in_xfer  = o_in_ack && i_in_rdy;
    assign ps_xfer  = i_mac_busy && i_ps_ack;

    // ==================================================================
    // compute issue and pad addressing
    // ==================================================================
    assign issue_first = (cmp_idx[1] == '0) && (cmp_idx[0] == '0);
    assign issue_last  = cmp_end[1] && cmp_end[0];

    // output register must be free when the last add lands
    assign hold_last = issue_last &&
                       ((i_mac_busy && !i_ps_ack) || (o_mac.valid && o_mac.last));
    assign issue     = (state == COMPUTE) && run_ok && !hold_last;

    // weights: c*filt_w + r, inputs: c*row_w + o + r
    assign wt_raddr = PAD_AW'(cmp_idx[1]) * PAD_AW'(conf.filt_w) + PAD_AW'(cmp_idx[0]);
    assign in_raddr = PAD_AW'(cmp_idx[1]) * PAD_AW'(row_w) + PAD_AW'(cmp_idx[2])
                    + PAD_AW'(cmp_idx[0]);

    assign o_wt_pad = '{write: wt_xfer, waddr: wr_cnt, read: issue, raddr: wt_raddr};
    assign o_in_pad = '{write: in_xfer, waddr: wr_cnt, read: issue, raddr: in_raddr};

    assign last_psum = ps_xfer && (ps_cnt == IN_IDX_W'(conf.out_w) - 1'b1);
    assign o_done    = (state == WAIT_OUT) && last_psum && !i_inst.abort;

    // ==================================================================
    // state machine
    // ==================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_inst.start) state_nxt = LOAD_WT;
            end
            LOAD_WT: begin
                if (wt_xfer && wt_all_end) state_nxt = LOAD_IN;
            end
            LOAD_IN: begin
                if (in_xfer && in_all_end) state_nxt = COMPUTE;
            end
            COMPUTE: begin
                if (issue && cmp_all_end) state_nxt = WAIT_OUT;
            end
            WAIT_OUT: begin
                if (last_psum) state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
        if (i_inst.abort) state_nxt = IDLE;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= IDLE;
            conf  <= '0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && i_inst.start) conf <= i_conf;
        end
    end

    // running write address, restarted for the input pad
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || state == IDLE || (wt_xfer && wt_all_end)) begin
            wr_cnt <= '0;
        end else if (wt_xfer || in_xfer) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || state == IDLE) begin
            ps_cnt <= '0;
        end else if (ps_xfer) begin
            ps_cnt <= ps_cnt + 1'b1;
        end
    end

    // pad read latency is one cycle
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_inst.abort) begin
            o_mac <= '0;
        end else begin
            o_mac <= '{valid: issue, first: issue_first, last: issue_last};
        end
    end

endmodule

// File: design/scratch_pad.sv
`timescale 1ns/1ps

module scratch_pad #(
    parameter int DEPTH = 32
) (
    input  logic                               i_clk,
    input  pe_pkg::pad_ctl_t                   i_ctl,
    input  logic signed [pe_pkg::ACT_W-1:0]    i_wdata,
    output logic signed [pe_pkg::ACT_W-1:0]    o_rdata
);
    import pe_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic signed [ACT_W-1:0] mem [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_ctl.write) begin
            mem[i_ctl.waddr[AW-1:0]] <= i_wdata;
        end
    end

    // read data holds until the next read, so it survives a stall
    always_ff @(posedge i_clk) begin
        if (i_ctl.read) begin
            o_rdata <= mem[i_ctl.raddr[AW-1:0]];
        end
    end

endmodule

// File: design/loop_counter.sv
`timescale 1ns/1ps

module loop_counter #(
    parameter int NDEPTH = 2,
    parameter int IDX_W  = 4
) (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_clear,
    input  logic                         i_inc,
    input  logic [NDEPTH-1:0][IDX_W-1:0] i_size,
    output logic [NDEPTH-1:0][IDX_W-1:0] o_idx,
    output logic [NDEPTH-1:0]            o_end,
    output logic                         o_all_end
);

    // carry[k] is set when level k steps this cycle
    logic [NDEPTH:0] carry;

    // level 0 is the innermost loop
    always_comb begin
        carry[0] = i_inc;
        for (int k = 0; k < NDEPTH; k++) begin
            o_end[k]     = (o_idx[k] == i_size[k] - 1'b1);
            carry[k + 1] = carry[k] && o_end[k];
        end
    end

    assign o_all_end = &o_end;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            o_idx <= '0;
        end else begin
            for (int k = 0; k < NDEPTH; k++) begin
                if (carry[k]) begin
                    // wrap to zero at the end of this level
                    if (o_end[k]) begin
                        o_idx[k] <= '0;
                    end else begin
                        o_idx[k] <= o_idx[k] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: design/pe_pkg.sv
package pe_pkg;

    // ==================================================================
    // datapath widths and supported loop sizes
    // ==================================================================
    localparam int ACT_W    = 8;
    localparam int PSUM_W   = 24;
    localparam int MAX_CH   = 4;
    localparam int MAX_FILT = 8;
    localparam int MAX_OUT  = 16;

    // pad address width, carried inside pad_ctl_t
    localparam int PAD_AW   = 7;

    // sampled on start
    typedef struct packed {
        logic [2:0] ch_num;
        logic [3:0] filt_w;
        logic [4:0] out_w;
    } pe_conf_t;

    typedef struct packed {
        logic start;
        logic abort;
        logic stall;
    } pe_inst_t;

    typedef struct packed {
        logic              write;
        logic [PAD_AW-1:0] waddr;
        logic              read;
        logic [PAD_AW-1:0] raddr;
    } pad_ctl_t;

    // aligned with pad read data, one cycle after the read
    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } mac_ctl_t;

    typedef enum logic [2:0] {IDLE, LOAD_WT, LOAD_IN, COMPUTE, WAIT_OUT} pe_state_e;

endpackage
